//--- tb.f
hdl/fifo_cfg_pkg.sv
hdl/fifo_word_pkg.sv
hdl/fifo_reset_sync.sv
hdl/fifo_dpram.sv
hdl/fifo_wr_ctrl.sv
hdl/fifo_rd_ctrl.sv
hdl/wide_to_narrow_fifo.sv
sim/tb_wide_to_narrow_fifo.sv

//--- Bender.yml
package:
  name: wide_to_narrow_fifo

sources:
  - files:
      - hdl/fifo_cfg_pkg.sv
      - hdl/fifo_word_pkg.sv
      - hdl/fifo_reset_sync.sv
      - hdl/fifo_dpram.sv
      - hdl/fifo_wr_ctrl.sv
      - hdl/fifo_rd_ctrl.sv
      - hdl/wide_to_narrow_fifo.sv
  - target: simulation
    files:
      - sim/tb_wide_to_narrow_fifo.sv

//--- sim/tb_wide_to_narrow_fifo.sv
`timescale 1ns/1ps

module tb_wide_to_narrow_fifo;

    localparam int STREAM_WORDS   = 64;
    localparam int FULL_WORDS     = fifo_cfg_pkg::WR_DEPTH + 1;   // memory plus held word
    localparam int TOTAL_WORDS    = 2 * STREAM_WORDS + FULL_WORDS + 1;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_WORDS + 500;
    localparam int HOLD_CYCLES    = 30;

    // read-side driver modes
    localparam int RD_LOW    = 0;
    localparam int RD_HIGH   = 1;
    localparam int RD_RANDOM = 2;
    localparam int RD_PULSE  = 3;

    logic                 wr_clock;
    logic                 rd_clock;
    logic                 rd_rst;
    logic                 wr_en;
    logic                 rd_en;
    fifo_word_pkg::word_t din;
    logic                 wr_ready;
    logic                 valid;
    fifo_word_pkg::lane_t dout;

    fifo_word_pkg::word_t word_q[$];     // words accepted but not fully read
    logic [31:0]          lcg_state  = 32'h7927;
    logic [31:0]          rd_rand;
    int                   rd_mode    = RD_LOW;
    int                   lane_pos   = 0;
    int                   words_in   = 0;
    int                   lanes_out  = 0;
    int                   mismatches = 0;
    int                   failures   = 0;
    int                   cycles     = 0;
    logic                 hold_pending = 1'b0;
    fifo_word_pkg::lane_t held_dout;

    wide_to_narrow_fifo UUT (
        .wr_clock (wr_clock),
        .rd_clock (rd_clock),
        .rd_rst   (rd_rst),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .din      (din),
        .wr_ready (wr_ready),
        .valid    (valid),
        .dout     (dout)
    );

    // rd edges at 2+4k and wr edges at 3+6k never line up
    initial begin
        rd_clock = 1'b0;
        forever #2 rd_clock = ~rd_clock;
    end

    initial begin
        wr_clock = 1'b0;
        forever #3 wr_clock = ~wr_clock;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // lane pos 0 is the most significant byte of the word
    function automatic fifo_word_pkg::lane_t expected_lane(input fifo_word_pkg::word_t word,
                                                           input int pos);
        return word[fifo_cfg_pkg::WR_WIDTH - 1 - pos * fifo_cfg_pkg::RD_WIDTH -:
                    fifo_cfg_pkg::RD_WIDTH];
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
            mismatches++;
        end
    endtask

    // writes count words with optional random idle cycles on wr_en
    task automatic write_words(input int count, input bit gaps);
        int                   sent;
        bit                   took;
        fifo_word_pkg::word_t data;
        logic [31:0]          r;
        sent = 0;
        data = next_rand();
        while (sent < count) begin
            @(posedge wr_clock);
            took = wr_en && wr_ready;
            if (took) begin
                word_q.push_back(data);
                sent++;
                words_in++;
            end
            #1;
            if (took) begin
                data = next_rand();
            end
            r     = next_rand();
            wr_en = (sent < count) && (!gaps || r[30]);
            din   = data;
        end
    endtask

    // fill with the reader stopped and then keep pushing against a full FIFO
    task automatic fill_and_hold();
        int                   accepted;
        fifo_word_pkg::word_t data;
        accepted = 0;
        data     = next_rand();
        @(posedge wr_clock);
        #1;
        wr_en = 1'b1;
        din   = data;
        while (accepted < FULL_WORDS) begin
            @(posedge wr_clock);
            if (wr_ready) begin
                word_q.push_back(data);
                accepted++;
                words_in++;
                data = next_rand();
            end
            #1 din = data;
        end
        repeat (HOLD_CYCLES) begin
            @(posedge wr_clock);
            check_equal(wr_ready, 1'b0, "wr_ready while full");
            if (wr_ready) begin
                word_q.push_back(data);   // keep the model in step if the DUT took it
                words_in++;
                data = next_rand();
            end
            #1 din = data;
        end
        wr_en = 1'b0;
    endtask

    task automatic wait_drained();
        while (word_q.size() != 0) @(posedge rd_clock);
        repeat (4) @(posedge rd_clock);
        check_equal(valid, 1'b0, "valid after drain");
    endtask

    always @(posedge rd_clock) begin
        #1;
        case (rd_mode)
            RD_HIGH:   rd_en = 1'b1;
            RD_RANDOM: begin
                rd_rand = next_rand();
                rd_en   = rd_rand[29];
            end
            RD_PULSE:  rd_en = ~rd_en;
            default:   rd_en = 1'b0;
        endcase
    end

    // compare every consumed lane with the model and check dout during stalls
    always @(posedge rd_clock) begin
        if (hold_pending) begin
            check_equal(valid, 1'b1, "valid dropped while stalled");
            check_equal(dout, held_dout, "dout changed while stalled");
        end
        if (valid === 1'b1 && rd_en === 1'b1) begin
            if (word_q.size() == 0) begin
                $display("lane consumed at %0t while no word was outstanding", $time);
                failures++;
            end else begin
                check_equal(dout, expected_lane(word_q[0], lane_pos), "lane data");
                lanes_out++;
                lane_pos++;
                if (lane_pos == fifo_cfg_pkg::LANES) begin
                    lane_pos = 0;
                    void'(word_q.pop_front());
                end
            end
        end
        hold_pending = (valid === 1'b1) && (rd_en === 1'b0);
        held_dout    = dout;
    end

    always @(posedge rd_clock) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout after %0d rd_clock cycles, %0d words still outstanding",
                     cycles, word_q.size());
            $display("errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int n;
        rd_rst = 1'b0;
        wr_en  = 1'b0;
        rd_en  = 1'b0;
        din    = '0;
        repeat (4) @(posedge rd_clock);
        #1 rd_rst = 1'b1;

        n = 0;
        while (wr_ready !== 1'b1 && n < 10) begin
            @(posedge wr_clock);
            n++;
        end
        if (wr_ready !== 1'b1) begin
            $display("wr_ready did not rise within ten wr_clock cycles of reset release");
            failures++;
        end
        rd_mode = RD_HIGH;   // reader asks before anything is written
        repeat (20) begin
            @(posedge rd_clock);
            check_equal(valid, 1'b0, "valid before any write");
        end

        write_words(STREAM_WORDS, 1'b0);
        wait_drained();

        rd_mode = RD_RANDOM;
        write_words(STREAM_WORDS, 1'b1);
        wait_drained();

        rd_mode = RD_LOW;
        fill_and_hold();
        rd_mode = RD_HIGH;
        wait_drained();

        rd_mode = RD_PULSE;  // pulses on an empty FIFO take nothing
        repeat (20) begin
            @(posedge rd_clock);
            check_equal(valid, 1'b0, "valid while empty");
        end
        write_words(1, 1'b0);
        wait_drained();

        check_equal(lanes_out, TOTAL_WORDS * fifo_cfg_pkg::LANES, "lanes read out");
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- hdl/wide_to_narrow_fifo.sv
`timescale 1ns/1ps

module wide_to_narrow_fifo (
    input  logic                  wr_clock,
    input  logic                  rd_clock,
    input  logic                  rd_rst,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  fifo_word_pkg::word_t  din,
    output logic                  wr_ready,
    output logic                  valid,
    output fifo_word_pkg::lane_t  dout
);

    logic                       rd_rst_sync;
    logic                       wr_rst_sync;
    fifo_cfg_pkg::ptr_t         wr_ptr_gray;   // wr_clock -> rd_clock
    fifo_cfg_pkg::ptr_t         rd_ptr_gray;   // rd_clock -> wr_clock
    logic                       ram_we;
    logic                       ram_re;
    fifo_cfg_pkg::addr_t        ram_wr_addr;
    fifo_cfg_pkg::addr_t        ram_rd_addr;
    fifo_word_pkg::fifo_word_u  ram_rd_data;

    fifo_reset_sync u_reset_sync (
        .rd_clock    (rd_clock),
        .wr_clock    (wr_clock),
        .rd_rst      (rd_rst),
        .rd_rst_sync (rd_rst_sync),
        .wr_rst_sync (wr_rst_sync)
    );

    fifo_wr_ctrl u_wr_ctrl (
        .wr_clock    (wr_clock),
        .wr_rst_sync (wr_rst_sync),
        .wr_en       (wr_en),
        .wr_ready    (wr_ready),
        .rd_ptr_gray (rd_ptr_gray),
        .wr_ptr_gray (wr_ptr_gray),
        .ram_we      (ram_we),
        .ram_wr_addr (ram_wr_addr)
    );

    fifo_dpram u_dpram (
        .wr_clock (wr_clock),
        .we       (ram_we),
        .wr_addr  (ram_wr_addr),
        .wr_data  (din),
        .rd_clock (rd_clock),
        .re       (ram_re),
        .rd_addr  (ram_rd_addr),
        .rd_data  (ram_rd_data)
    );

    fifo_rd_ctrl u_rd_ctrl (
        .rd_clock    (rd_clock),
        .rd_rst_sync (rd_rst_sync),
        .rd_en       (rd_en),
        .valid       (valid),
        .dout        (dout),
        .wr_ptr_gray (wr_ptr_gray),
        .rd_ptr_gray (rd_ptr_gray),
        .ram_re      (ram_re),
        .ram_rd_addr (ram_rd_addr),
        .ram_rd_data (ram_rd_data)
    );

endmodule

//--- hdl/fifo_rd_ctrl.sv
`timescale 1ns/1ps

module fifo_rd_ctrl (
    input  logic                       rd_clock,
    input  logic                       rd_rst_sync,
    input  logic                       rd_en,
    output logic                       valid,
    output fifo_word_pkg::lane_t       dout,
    input  fifo_cfg_pkg::ptr_t         wr_ptr_gray,
    output fifo_cfg_pkg::ptr_t         rd_ptr_gray,
    output logic                       ram_re,
    output fifo_cfg_pkg::addr_t        ram_rd_addr,
    input  fifo_word_pkg::fifo_word_u  ram_rd_data
);

    fifo_cfg_pkg::ptr_t      rd_ptr_bin;
    fifo_cfg_pkg::ptr_t      rd_ptr_next;
    fifo_cfg_pkg::ptr_t      wr_sync1;
    fifo_cfg_pkg::ptr_t      wr_sync2;
    fifo_cfg_pkg::lane_idx_t lane_idx;
    logic                    word_held;   // memory read register holds an unread word
    logic                    empty;
    logic                    take;
    logic                    last_take;
    logic                    fetch;

    // two-stage sync of the write pointer into rd_clock
    always_ff @(posedge rd_clock or negedge rd_rst_sync) begin
        if (!rd_rst_sync) begin
            wr_sync1 <= '0;
            wr_sync2 <= '0;
        end else begin
            wr_sync1 <= wr_ptr_gray;
            wr_sync2 <= wr_sync1;
        end
    end

    // empty counts only memory words and not the held word
    assign empty = (wr_sync2 == rd_ptr_gray);

    assign take      = word_held & rd_en;                    // lane consumed this edge
    assign last_take = take & (lane_idx == '0);

    // prefetch fills an empty holding register or refills it as its last lane leaves
    assign fetch = ~empty & (~word_held | last_take);

    assign rd_ptr_next = rd_ptr_bin + 1'b1;

    // pointer moves with each fetch and not per lane
    always_ff @(posedge rd_clock or negedge rd_rst_sync) begin
        if (!rd_rst_sync) begin
            rd_ptr_bin  <= '0;
            rd_ptr_gray <= '0;
        end else if (fetch) begin
            rd_ptr_bin  <= rd_ptr_next;
            rd_ptr_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
        end
    end

    // data lands in the read register at the fetch edge
    always_ff @(posedge rd_clock or negedge rd_rst_sync) begin
        if (!rd_rst_sync) begin
            word_held <= 1'b0;
        end else if (fetch) begin
            word_held <= 1'b1;
        end else if (last_take) begin
            word_held <= 1'b0;   // drained and nothing to refill
        end
    end

    // msb lane first and count down per consumed lane
    always_ff @(posedge rd_clock or negedge rd_rst_sync) begin
        if (!rd_rst_sync) begin
            lane_idx <= fifo_cfg_pkg::lane_idx_t'(fifo_cfg_pkg::LANES - 1);
        end else if (fetch) begin
            lane_idx <= fifo_cfg_pkg::lane_idx_t'(fifo_cfg_pkg::LANES - 1);
        end else if (take) begin
            lane_idx <= lane_idx - 1'b1;
        end
    end

    assign ram_re      = fetch;
    assign ram_rd_addr = rd_ptr_bin[fifo_cfg_pkg::ADDR_W-1:0];

    assign valid = word_held;
    assign dout  = ram_rd_data.lanes[lane_idx];

endmodule

//--- hdl/fifo_wr_ctrl.sv
`timescale 1ns/1ps

module fifo_wr_ctrl (
    input  logic                 wr_clock,
    input  logic                 wr_rst_sync,
    input  logic                 wr_en,
    output logic                 wr_ready,
    input  fifo_cfg_pkg::ptr_t   rd_ptr_gray,
    output fifo_cfg_pkg::ptr_t   wr_ptr_gray,
    output logic                 ram_we,
    output fifo_cfg_pkg::addr_t  ram_wr_addr
);

    fifo_cfg_pkg::ptr_t wr_ptr_bin;
    fifo_cfg_pkg::ptr_t wr_ptr_next;
    fifo_cfg_pkg::ptr_t rd_sync1;
    fifo_cfg_pkg::ptr_t rd_sync2;
    logic               wr_armed;
    logic               full;

    assign wr_ptr_next = wr_ptr_bin + 1'b1;

    // binary counter plus registered gray copy so one bit flips per step
    always_ff @(posedge wr_clock or negedge wr_rst_sync) begin
        if (!wr_rst_sync) begin
            wr_ptr_bin  <= '0;
            wr_ptr_gray <= '0;
        end else if (ram_we) begin
            wr_ptr_bin  <= wr_ptr_next;
            wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
        end
    end

    // two-stage sync of the read pointer into wr_clock
    always_ff @(posedge wr_clock or negedge wr_rst_sync) begin
        if (!wr_rst_sync) begin
            rd_sync1 <= '0;
            rd_sync2 <= '0;
        end else begin
            rd_sync1 <= rd_ptr_gray;
            rd_sync2 <= rd_sync1;
        end
    end

    // accept nothing until the first cycle out of reset
    always_ff @(posedge wr_clock or negedge wr_rst_sync) begin
        if (!wr_rst_sync) begin
            wr_armed <= 1'b0;
        end else begin
            wr_armed <= 1'b1;
        end
    end

    // full when the top two gray bits are inverted and the rest equal
    assign full = (wr_ptr_gray[fifo_cfg_pkg::PTR_W-1 -: 2] ==
                   ~rd_sync2[fifo_cfg_pkg::PTR_W-1 -: 2]) &&
                  (wr_ptr_gray[fifo_cfg_pkg::PTR_W-3:0] ==
                   rd_sync2[fifo_cfg_pkg::PTR_W-3:0]);

    assign wr_ready    = wr_armed & ~full;
    assign ram_we      = wr_en & wr_ready;
    assign ram_wr_addr = wr_ptr_bin[fifo_cfg_pkg::ADDR_W-1:0];   // wrap bit dropped

endmodule

//--- hdl/fifo_dpram.sv
`timescale 1ns/1ps

module fifo_dpram (
    input  logic                       wr_clock,
    input  logic                       we,
    input  fifo_cfg_pkg::addr_t        wr_addr,
    input  fifo_word_pkg::word_t       wr_data,
    input  logic                       rd_clock,
    input  logic                       re,
    input  fifo_cfg_pkg::addr_t        rd_addr,
    output fifo_word_pkg::fifo_word_u  rd_data
);

    fifo_word_pkg::word_t mem [fifo_cfg_pkg::WR_DEPTH];

    // write port takes the whole word at once
    always_ff @(posedge wr_clock) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read register keeps the last word while re is low
    // so the read side drains its lanes straight from here
    always_ff @(posedge rd_clock) begin
        if (re) begin
            rd_data.flat <= mem[rd_addr];
        end
    end

endmodule

//--- hdl/fifo_reset_sync.sv
`timescale 1ns/1ps

module fifo_reset_sync (
    input  logic rd_clock,
    input  logic wr_clock,
    input  logic rd_rst,
    output logic rd_rst_sync,
    output logic wr_rst_sync
);

    logic rd_meta;
    logic wr_meta;

    // read domain leaves reset first
    always_ff @(posedge rd_clock or negedge rd_rst) begin
        if (!rd_rst) begin
            rd_meta     <= 1'b0;
            rd_rst_sync <= 1'b0;
        end else begin
            rd_meta     <= 1'b1;
            rd_rst_sync <= rd_meta;
        end
    end

    // write domain follows the released read-domain reset
    always_ff @(posedge wr_clock or negedge rd_rst) begin
        if (!rd_rst) begin
            wr_meta     <= 1'b0;
            wr_rst_sync <= 1'b0;
        end else begin
            wr_meta     <= rd_rst_sync;   // crosses from rd_clock
            wr_rst_sync <= wr_meta;
        end
    end

endmodule

//--- hdl/fifo_word_pkg.sv
package fifo_word_pkg;

    // one narrow lane on the read side
    typedef logic [fifo_cfg_pkg::RD_WIDTH-1:0] lane_t;

    // one full word on the write side
    typedef logic [fifo_cfg_pkg::WR_WIDTH-1:0] word_t;

    // same stored word seen flat by the write path and as lanes by the read path
    // lanes[LANES-1] is the most significant byte
    typedef union packed {
        word_t                                 flat;
        lane_t [fifo_cfg_pkg::LANES-1:0]       lanes;
    } fifo_word_u;

endpackage

//--- hdl/fifo_cfg_pkg.sv
package fifo_cfg_pkg;

    // data widths on the two sides
    localparam int WR_WIDTH = 32;
    localparam int RD_WIDTH = 8;
    localparam int LANES    = WR_WIDTH / RD_WIDTH;   // lanes per written word

    // memory geometry
    localparam int WR_DEPTH = 16;
    localparam int ADDR_W   = $clog2(WR_DEPTH);
    localparam int PTR_W    = ADDR_W + 1;            // extra wrap bit for full/empty
    localparam int LANE_W   = $clog2(LANES);

    // binary and gray pointers share one type
    typedef logic [PTR_W-1:0] ptr_t;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [LANE_W-1:0] lane_idx_t;

endpackage
